/* sim.f */
src/axil_pkg.sv
src/axil_slave_write.sv
src/axil_slave_read.sv
src/axil_reg_bank.sv
src/axil_regs_top.sv
verification/axil_regs_chk.sv
verification/tb_axil_regs.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_axil_regs
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
RUN_ARGS   := +verilator+error+limit+1000
FAIL_MSG   := *** FAILED ***
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_axil_regs.sv */
`timescale 1ns/100ps

module tb_axil_regs;
	localparam int CLK_PERIOD = 4;
	localparam int TEST_COUNT = 6;
	localparam int CYCLES_PER_TEST = 200;

	logic clk;
	logic rst_n;
	axil_pkg::addr_t s_axi_awaddr;
	logic [2:0] s_axi_awprot;
	logic s_axi_awvalid;
	logic s_axi_awready;
	axil_pkg::data_t s_axi_wdata;
	axil_pkg::strb_t s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	axil_pkg::resp_t s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	axil_pkg::addr_t s_axi_araddr;
	logic [2:0] s_axi_arprot;
	logic s_axi_arvalid;
	logic s_axi_arready;
	axil_pkg::data_t s_axi_rdata;
	axil_pkg::resp_t s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;

	// Expected register contents.
	axil_pkg::data_t model [axil_pkg::REG_COUNT];
	int seed;
	int test_errors;
	int pass_count;
	int fail_count;

	axil_regs_top i_dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic axil_pkg::resp_t expected_resp(input axil_pkg::addr_t addr);
		return (addr < 7'h20) ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
	endfunction

	function automatic axil_pkg::data_t expected_data(input axil_pkg::addr_t addr);
		return (addr < 7'h20) ? model[addr[4:2]] : '0;
	endfunction

	task automatic apply_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
			input axil_pkg::strb_t strb);
		if (addr < 7'h20) begin
			for (int b = 0; b < 4; b++)
				if (strb[b])
					model[addr[4:2]][b*8 +: 8] = data[b*8 +: 8];
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic axi_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
			input axil_pkg::strb_t strb, output axil_pkg::resp_t resp, input int stall = 0);
		@(negedge clk);
		s_axi_awaddr = addr;
		s_axi_awvalid = 1'b1;
		while (!s_axi_awready)
			@(negedge clk);
		@(negedge clk);
		s_axi_awvalid = 1'b0;
		s_axi_wdata = data;
		s_axi_wstrb = strb;
		s_axi_wvalid = 1'b1;
		while (!s_axi_wready)
			@(negedge clk);
		@(negedge clk);
		s_axi_wvalid = 1'b0;
		while (!s_axi_bvalid)
			@(negedge clk);
		repeat (stall)
			@(negedge clk);
		resp = s_axi_bresp;
		s_axi_bready = 1'b1;
		@(negedge clk);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input axil_pkg::addr_t addr, output axil_pkg::data_t data,
			output axil_pkg::resp_t resp, input int stall = 0);
		@(negedge clk);
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		while (!s_axi_arready)
			@(negedge clk);
		@(negedge clk);
		s_axi_arvalid = 1'b0;
		while (!s_axi_rvalid)
			@(negedge clk);
		repeat (stall)
			@(negedge clk);
		data = s_axi_rdata;
		resp = s_axi_rresp;
		s_axi_rready = 1'b1;
		@(negedge clk);
		s_axi_rready = 1'b0;
	endtask

	task automatic write_check(input string name, input axil_pkg::addr_t addr,
			input axil_pkg::data_t data, input axil_pkg::strb_t strb, input int stall = 0);
		axil_pkg::resp_t resp;
		axi_write(addr, data, strb, resp, stall);
		check($sformatf("%s bresp @%h", name, addr), 32'(expected_resp(addr)), 32'(resp));
		apply_write(addr, data, strb);
	endtask

	task automatic read_check(input string name, input axil_pkg::addr_t addr,
			input int stall = 0);
		axil_pkg::data_t data;
		axil_pkg::resp_t resp;
		axi_read(addr, data, resp, stall);
		check($sformatf("%s rdata @%h", name, addr), expected_data(addr), data);
		check($sformatf("%s rresp @%h", name, addr), 32'(expected_resp(addr)), 32'(resp));
	endtask

	task automatic read_all(input string name);
		for (int i = 0; i < axil_pkg::REG_COUNT; i++)
			read_check(name, axil_pkg::addr_t'(i * 4));
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("test %s passed", name);
			pass_count++;
		end else begin
			$display("test %s failed with %0d errors", name, test_errors);
			fail_count++;
		end
		test_errors = 0;
	endtask

	// Watchdog.
	initial begin
		#(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
		$display("Run timed out after %0d ns", TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic [31:0] r;
		axil_pkg::addr_t addr;
		int stall;
		clk = 1'b0;
		rst_n = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awprot = 3'd0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arprot = 3'd0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		seed = 32'h9ee2;
		test_errors = 0;
		pass_count = 0;
		fail_count = 0;
		for (int i = 0; i < axil_pkg::REG_COUNT; i++)
			model[i] = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// AWREADY and ARREADY come up one cycle after reset.
		check("reset bvalid", 32'd0, 32'(s_axi_bvalid));
		check("reset rvalid", 32'd0, 32'(s_axi_rvalid));
		check("reset wready", 32'd0, 32'(s_axi_wready));
		check("reset awready", 32'd1, 32'(s_axi_awready));
		check("reset arready", 32'd1, 32'(s_axi_arready));
		read_all("reset");
		finish_test("reset_values");

		for (int i = 0; i < axil_pkg::REG_COUNT; i++)
			write_check("full", axil_pkg::addr_t'(i * 4), $random(seed), 4'hf);
		read_all("full");
		finish_test("full_strobe");

		// Strobe patterns include the empty one.
		for (int i = 0; i < axil_pkg::REG_COUNT; i++)
			write_check("partial", axil_pkg::addr_t'(i * 4 + i % 4), $random(seed),
				axil_pkg::strb_t'(i * 3 + 1));
		read_all("partial");
		finish_test("partial_strobe");

		for (int a = 'h20; a < 'h80; a += 13) begin
			write_check("slverr", axil_pkg::addr_t'(a), $random(seed), 4'hf);
			read_check("slverr", axil_pkg::addr_t'(a));
		end
		write_check("slverr", 7'h7f, $random(seed), 4'hf);
		read_check("slverr", 7'h7f);
		read_all("slverr intact");
		finish_test("slverr_range");

		fork
			write_check("stall", 7'h08, $random(seed), 4'hf, 6);
			read_check("stall", 7'h10, 5);
		join
		write_check("stall", 7'h14, $random(seed), 4'h6, 4);
		read_check("stall", 7'h08, 7);
		read_check("stall", 7'h14, 3);
		finish_test("back_pressure");

		for (int n = 0; n < 40; n++) begin
			r = $random(seed);
			addr = r[8] ? r[6:0] : {2'b00, r[4:0]};
			stall = int'(r[11:10]);
			if (r[12])
				write_check("random", addr, $random(seed), r[16:13], stall);
			else
				read_check("random", addr, stall);
		end
		read_all("random final");
		finish_test("random_traffic");

		$display("Tests: %0d passed, %0d failed, %0d assertion failures",
			pass_count, fail_count, i_dut.u_chk.assert_failures);
		if (fail_count == 0 && i_dut.u_chk.assert_failures == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end
endmodule

/* verification/axil_regs_chk.sv */
`timescale 1ns/100ps

module axil_regs_chk (
	input logic clk,
	input logic rst_n,
	input logic s_axi_awready,
	input logic s_axi_wready,
	input logic s_axi_bvalid,
	input logic s_axi_bready,
	input axil_pkg::resp_t s_axi_bresp,
	input logic s_axi_arready,
	input logic s_axi_rvalid,
	input logic s_axi_rready,
	input axil_pkg::data_t s_axi_rdata,
	input axil_pkg::resp_t s_axi_rresp,
	input logic write_req,
	input logic write_ready
);
	int assert_failures;
	logic write_acked;

	// Set once the bank has answered the current write request.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			write_acked <= 1'b0;
		else
			write_acked <= write_req & (write_acked | write_ready);
	end

	reset_quiet: assert property (@(posedge clk) !rst_n |-> !s_axi_awready && !s_axi_wready
		&& !s_axi_bvalid && !s_axi_arready && !s_axi_rvalid)
		else begin
			$error("handshake output high during reset");
			assert_failures++;
		end

	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
		else begin
			$error("B response changed before BREADY");
			assert_failures++;
		end

	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
		&& $stable(s_axi_rresp))
		else begin
			$error("R response changed before RREADY");
			assert_failures++;
		end

	aw_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_bvalid |-> !s_axi_awready)
		else begin
			$error("AWREADY high while BVALID pending");
			assert_failures++;
		end

	ar_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_rvalid |-> !s_axi_arready)
		else begin
			$error("ARREADY high while RVALID pending");
			assert_failures++;
		end

	single_ack: assert property (@(posedge clk) disable iff (!rst_n)
		write_ready |-> !write_acked)
		else begin
			$error("second write_ready within one write_req");
			assert_failures++;
		end
endmodule

bind axil_regs_top axil_regs_chk u_chk (
	.clk           (clk),
	.rst_n         (rst_n),
	.s_axi_awready (s_axi_awready),
	.s_axi_wready  (s_axi_wready),
	.s_axi_bvalid  (s_axi_bvalid),
	.s_axi_bready  (s_axi_bready),
	.s_axi_bresp   (s_axi_bresp),
	.s_axi_arready (s_axi_arready),
	.s_axi_rvalid  (s_axi_rvalid),
	.s_axi_rready  (s_axi_rready),
	.s_axi_rdata   (s_axi_rdata),
	.s_axi_rresp   (s_axi_rresp),
	.write_req     (write_req),
	.write_ready   (write_ready)
);

/* src/axil_regs_top.sv */
`timescale 1ns/100ps

module axil_regs_top (
	input logic clk,
	input logic rst_n,

	input axil_pkg::addr_t s_axi_awaddr,
	input logic [2:0] s_axi_awprot,
	input logic s_axi_awvalid,
	output logic s_axi_awready,

	input axil_pkg::data_t s_axi_wdata,
	input axil_pkg::strb_t s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,

	output axil_pkg::resp_t s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,

	input axil_pkg::addr_t s_axi_araddr,
	input logic [2:0] s_axi_arprot,
	input logic s_axi_arvalid,
	output logic s_axi_arready,

	output axil_pkg::data_t s_axi_rdata,
	output axil_pkg::resp_t s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready
);
	logic write_req;
	axil_pkg::addr_t write_addr;
	axil_pkg::data_t write_data;
	axil_pkg::strb_t write_strb;
	logic write_ready;
	logic write_response;

	logic read_req;
	axil_pkg::addr_t read_addr;
	logic read_ready;
	axil_pkg::data_t read_data;
	logic read_response;

	axil_slave_write u_write (
		.clk            (clk),
		.rst_n          (rst_n),
		.s_axi_awaddr   (s_axi_awaddr),
		.s_axi_awprot   (s_axi_awprot),
		.s_axi_awvalid  (s_axi_awvalid),
		.s_axi_awready  (s_axi_awready),
		.s_axi_wdata    (s_axi_wdata),
		.s_axi_wstrb    (s_axi_wstrb),
		.s_axi_wvalid   (s_axi_wvalid),
		.s_axi_wready   (s_axi_wready),
		.s_axi_bresp    (s_axi_bresp),
		.s_axi_bvalid   (s_axi_bvalid),
		.s_axi_bready   (s_axi_bready),
		.write_req      (write_req),
		.write_addr     (write_addr),
		.write_data     (write_data),
		.write_strb     (write_strb),
		.write_ready    (write_ready),
		.write_response (write_response)
	);

	axil_slave_read u_read (
		.clk           (clk),
		.rst_n         (rst_n),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arprot  (s_axi_arprot),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.read_req      (read_req),
		.read_addr     (read_addr),
		.read_ready    (read_ready),
		.read_data     (read_data),
		.read_response (read_response)
	);

	axil_reg_bank u_bank (
		.clk            (clk),
		.rst_n          (rst_n),
		.write_req      (write_req),
		.write_addr     (write_addr),
		.write_data     (write_data),
		.write_strb     (write_strb),
		.write_ready    (write_ready),
		.write_response (write_response),
		.read_req       (read_req),
		.read_addr      (read_addr),
		.read_ready     (read_ready),
		.read_data      (read_data),
		.read_response  (read_response)
	);
endmodule

/* src/axil_reg_bank.sv */
`timescale 1ns/100ps

module axil_reg_bank (
	input logic clk,
	input logic rst_n,

	input logic write_req,
	input axil_pkg::addr_t write_addr,
	input axil_pkg::data_t write_data,
	input axil_pkg::strb_t write_strb,
	output logic write_ready,
	output logic write_response,

	input logic read_req,
	input axil_pkg::addr_t read_addr,
	output logic read_ready,
	output axil_pkg::data_t read_data,
	output logic read_response
);
	localparam int INDEX_LSB = 2;
	localparam int INDEX_MSB = axil_pkg::REG_INDEX_WIDTH + INDEX_LSB - 1;

	axil_pkg::data_t regs [axil_pkg::REG_COUNT];

	logic write_done;
	logic read_done;

	logic write_valid;
	logic read_valid;
	logic [axil_pkg::REG_INDEX_WIDTH-1:0] write_index;
	logic [axil_pkg::REG_INDEX_WIDTH-1:0] read_index;

	// Only word addresses 0x00..0x1C map onto a register.
	assign write_valid = write_addr[axil_pkg::ADDR_WIDTH-1:INDEX_MSB+1] == '0;
	assign read_valid = read_addr[axil_pkg::ADDR_WIDTH-1:INDEX_MSB+1] == '0;
	assign write_index = write_addr[INDEX_MSB:INDEX_LSB];
	assign read_index = read_addr[INDEX_MSB:INDEX_LSB];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < axil_pkg::REG_COUNT; i++)
				regs[i] <= '0;
			write_done <= 1'b0;
			write_ready <= 1'b0;
		end else begin
			write_ready <= 1'b0;
			if (!write_req) begin
				write_done <= 1'b0;
			end else if (!write_done) begin
				// One commit per request, only the enabled bytes.
				write_done <= 1'b1;
				write_ready <= 1'b1;
				if (write_valid) begin
					for (int b = 0; b < axil_pkg::STRB_WIDTH; b++)
						if (write_strb[b])
							regs[write_index][b*8 +: 8] <= write_data[b*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_done <= 1'b0;
			read_ready <= 1'b0;
		end else begin
			read_ready <= read_req & ~read_done;
			read_done <= read_req;
		end
	end

	// Responses are sampled by the channel blocks only with the ready pulse.
	always_ff @(posedge clk) begin
		if (write_req && !write_done)
			write_response <= write_valid;
		if (read_req && !read_done) begin
			read_response <= read_valid;
			read_data <= read_valid ? regs[read_index] : '0;
		end
	end
endmodule

/* src/axil_slave_read.sv */
`timescale 1ns/100ps

module axil_slave_read (
	input logic clk,
	input logic rst_n,

	input axil_pkg::addr_t s_axi_araddr,
	input logic [2:0] s_axi_arprot,
	input logic s_axi_arvalid,
	output logic s_axi_arready,

	output axil_pkg::data_t s_axi_rdata,
	output axil_pkg::resp_t s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,

	output logic read_req,
	output axil_pkg::addr_t read_addr,
	input logic read_ready,
	input axil_pkg::data_t read_data,
	input logic read_response
);
	typedef enum logic [1:0] {
		ST_R_WAIT_ADDR,
		ST_R_WAIT_BANK,
		ST_R_RESPONSE
	} state_t;

	state_t state, state_next;

	logic arready_next;
	logic rvalid_next;
	axil_pkg::resp_t rresp_next;
	logic read_req_next;

	logic ar_fire;
	logic r_fire;

	assign ar_fire = s_axi_arvalid & s_axi_arready;
	assign r_fire = s_axi_rvalid & s_axi_rready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_R_WAIT_ADDR;
			s_axi_arready <= 1'b0;
			s_axi_rvalid <= 1'b0;
			s_axi_rresp <= axil_pkg::RESP_OKAY;
			read_req <= 1'b0;
		end else begin
			state <= state_next;
			s_axi_arready <= arready_next;
			s_axi_rvalid <= rvalid_next;
			s_axi_rresp <= rresp_next;
			read_req <= read_req_next;
		end
	end

	// Bank data is captured once and then held until RREADY.
	always_ff @(posedge clk) begin
		if (ar_fire && state == ST_R_WAIT_ADDR)
			read_addr <= s_axi_araddr;
		if (read_ready && state == ST_R_WAIT_BANK)
			s_axi_rdata <= read_data;
	end

	always_comb begin
		state_next = state;
		arready_next = s_axi_arready;
		rvalid_next = s_axi_rvalid;
		rresp_next = s_axi_rresp;
		read_req_next = read_req;

		case (state)
			ST_R_WAIT_ADDR: begin
				arready_next = 1'b1;
				if (ar_fire) begin
					state_next = ST_R_WAIT_BANK;
					arready_next = 1'b0;
					read_req_next = 1'b1;
				end
			end

			ST_R_WAIT_BANK: begin
				if (read_ready) begin
					state_next = ST_R_RESPONSE;
					read_req_next = 1'b0;
					rvalid_next = 1'b1;
					rresp_next = read_response ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
				end
			end

			ST_R_RESPONSE: begin
				if (r_fire) begin
					state_next = ST_R_WAIT_ADDR;
					arready_next = 1'b1;
					rvalid_next = 1'b0;
				end
			end

			default: state_next = ST_R_WAIT_ADDR;
		endcase
	end
endmodule

/* src/axil_slave_write.sv */
`timescale 1ns/100ps

module axil_slave_write (
	input logic clk,
	input logic rst_n,

	input axil_pkg::addr_t s_axi_awaddr,
	input logic [2:0] s_axi_awprot,
	input logic s_axi_awvalid,
	output logic s_axi_awready,

	input axil_pkg::data_t s_axi_wdata,
	input axil_pkg::strb_t s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,

	output axil_pkg::resp_t s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,

	output logic write_req,
	output axil_pkg::addr_t write_addr,
	output axil_pkg::data_t write_data,
	output axil_pkg::strb_t write_strb,
	input logic write_ready,
	input logic write_response
);
	typedef enum logic [1:0] {
		ST_W_WAIT_ADDR,
		ST_W_WAIT_DATA,
		ST_W_RESPONSE
	} state_t;

	state_t state, state_next;

	logic awready_next;
	logic wready_next;
	logic bvalid_next;
	axil_pkg::resp_t bresp_next;
	logic write_req_next;

	logic aw_fire;
	logic w_fire;
	logic b_fire;

	assign aw_fire = s_axi_awvalid & s_axi_awready;
	assign w_fire = s_axi_wvalid & s_axi_wready;
	assign b_fire = s_axi_bvalid & s_axi_bready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_W_WAIT_ADDR;
			s_axi_awready <= 1'b0;
			s_axi_wready <= 1'b0;
			s_axi_bvalid <= 1'b0;
			s_axi_bresp <= axil_pkg::RESP_OKAY;
			write_req <= 1'b0;
		end else begin
			state <= state_next;
			s_axi_awready <= awready_next;
			s_axi_wready <= wready_next;
			s_axi_bvalid <= bvalid_next;
			s_axi_bresp <= bresp_next;
			write_req <= write_req_next;
		end
	end

	// Address and data are held for the bank until the next transaction.
	always_ff @(posedge clk) begin
		if (aw_fire && state == ST_W_WAIT_ADDR)
			write_addr <= s_axi_awaddr;
		if (w_fire && state == ST_W_WAIT_DATA) begin
			write_data <= s_axi_wdata;
			write_strb <= s_axi_wstrb;
		end
	end

	always_comb begin
		state_next = state;
		awready_next = s_axi_awready;
		wready_next = s_axi_wready;
		bvalid_next = s_axi_bvalid;
		bresp_next = s_axi_bresp;
		write_req_next = write_req;

		case (state)
			ST_W_WAIT_ADDR: begin
				awready_next = 1'b1;
				if (aw_fire) begin
					state_next = ST_W_WAIT_DATA;
					awready_next = 1'b0;
					wready_next = 1'b1;
				end
			end

			ST_W_WAIT_DATA: begin
				if (w_fire) begin
					state_next = ST_W_RESPONSE;
					wready_next = 1'b0;
					write_req_next = 1'b1;
				end
			end

			ST_W_RESPONSE: begin
				if (b_fire) begin
					state_next = ST_W_WAIT_ADDR;
					awready_next = 1'b1;
					bvalid_next = 1'b0;
					write_req_next = 1'b0;
				end else if (write_ready) begin
					bvalid_next = 1'b1;
					bresp_next = write_response ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
				end
			end

			default: state_next = ST_W_WAIT_ADDR;
		endcase
	end
endmodule

/* src/axil_pkg.sv */
package axil_pkg;

	// AXI4-Lite bus widths.
	localparam int ADDR_WIDTH = 7;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	// Register file geometry, word addressed.
	localparam int REG_COUNT = 8;
	localparam int REG_INDEX_WIDTH = 3;

	localparam logic [1:0] RESP_OKAY = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	// Byte address on the bus.
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// Register and bus data.
	typedef logic [DATA_WIDTH-1:0] data_t;

	// Byte enables.
	typedef logic [STRB_WIDTH-1:0] strb_t;

	// AXI response code.
	typedef logic [1:0] resp_t;

endpackage
